/* vlog.f */
common/uart_cfg_pkg.sv
common/uart_cmd_pkg.sv
uart_phy/uart_tx_frame.sv
uart_phy/uart_rx_frame.sv
hdl/uart_cmd_ctrl.sv
hdl/uart_cmd_top.sv
tb/uart_cmd_sva.sv
tb/uart_cmd_tb.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module uart_cmd_tb -f vlog.f -o uart_cmd_sim \
  && ./obj_dir/uart_cmd_sim > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "Build or run error"; exit 1; }
cat sim.log
grep -q "SOME TESTS FAILED" sim.log && { echo "Simulation failed"; exit 1; } \
  || echo "Simulation passed"

/* tb/uart_cmd_tb.sv */
`timescale 1ns/100ps

module uart_cmd_tb;

  import uart_cfg_pkg::*;
  import uart_cmd_pkg::*;

  typedef enum logic [1:0] {
    reply_ok,
    reply_bad_par,
    reply_none
  } reply_mode_e;

  localparam int N_ROWS     = 8;
  localparam int WAIT_LIMIT = 64 * BAUD_DIV;  // Well past the reply timeout

  logic  clk;
  logic  rst_n;
  cmd_t  cmd_in;
  logic  cmd_vld;
  logic  rx;
  logic  tx;
  logic  cmd_rdy;
  logic  read_rdy;
  logic  rsp_err;
  data_t read_data;

  // Command table
  cmd_op_e     row_op [N_ROWS];
  addr_t       row_addr [N_ROWS];
  data_t       row_data [N_ROWS];
  reply_mode_e row_mode [N_ROWS];
  int          row_delay [N_ROWS];  // Bit times before the slave answers
  logic        row_err [N_ROWS];

  data_t shadow_mem [128];  // Slave register file
  int    seed;
  int    mismatches;
  int    other_errors;
  int    frames_seen;
  int    frames_exp;
  int    accepts;
  int    frame_left;  // Clocks left in the frame being watched

  uart_cmd_top uart_cmd_top_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .rx        (rx),
    .tx        (tx),
    .cmd_rdy   (cmd_rdy),
    .read_rdy  (read_rdy),
    .rsp_err   (rsp_err),
    .read_data (read_data)
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Counts accepted commands and frames on tx
  always @(posedge clk)
  begin
    if (rst_n && cmd_vld && cmd_rdy)
      accepts++;
    if (frame_left > 0)
      frame_left--;
    else if (rst_n && !tx)
    begin
      frames_seen++;
      frame_left = FRAME_BITS * BAUD_DIV - 1;
    end
  end

  function automatic logic parity_of(data_t b);
    logic p;
    int   i;
    p = PARITY_ODD;
    for (i = 0; i < DATA_BITS; i++)
      p = p ^ b[i];
    return p;
  endfunction

  function automatic cmd_t make_cmd(int r);
    return {row_op[r], row_addr[r], row_data[r]};
  endfunction

  task automatic set_row(int r, cmd_op_e op, addr_t a, reply_mode_e m, int d, logic e);
    row_op[r]    = op;
    row_addr[r]  = a;
    row_mode[r]  = m;
    row_delay[r] = d;
    row_err[r]   = e;
    row_data[r]  = (op == op_write) ? data_t'($random(seed)) : '0;
  endtask

  task automatic check_data(string name, data_t got, data_t exp);
    if (got !== exp)
    begin
      mismatches++;
      $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_err(string name, logic got, logic exp);
    if (got !== exp)
    begin
      mismatches++;
      $display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic check_cmd_byte(string name, data_t got, data_t exp);
    if (got !== exp)
    begin
      mismatches++;
      $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic print_counts;
    $display("Summary: %0d mismatches, %0d other errors", mismatches, other_errors);
  endtask

  task automatic abort_run(string why);
    other_errors++;
    $display("Timeout at %0t: %s", $time, why);
    print_counts();
    $display("SOME TESTS FAILED");
    $finish;
  endtask

  // Returns on the edge where the DUT takes the command
  task automatic wait_accept;
    int n;
    n = 0;
    @(posedge clk);
    while (!(cmd_vld && cmd_rdy))
    begin
      n++;
      if (n > WAIT_LIMIT)
        abort_run("cmd_rdy never returned high");
      @(posedge clk);
    end
  endtask

  task automatic wait_tx_low(output int cycles);
    cycles = 0;
    do
    begin
      @(posedge clk);
      cycles++;
      if (cycles > WAIT_LIMIT)
        abort_run("no start bit appeared on tx");
    end while (tx);
  endtask

  task automatic wait_read_rdy;
    int n;
    n = 0;
    do
    begin
      @(posedge clk);
      n++;
      if (n > WAIT_LIMIT)
        abort_run("read_rdy never pulsed");
    end while (!read_rdy);
  endtask

  // Slave receiver that samples tx at mid-bit
  task automatic check_frame(string name, data_t exp, output int idle);
    data_t b;
    logic  par;
    int    i;
    wait_tx_low(idle);
    repeat (HALF_BAUD - 1) @(posedge clk);
    if (tx)
    begin
      other_errors++;
      $display("Start bit of the %s went high before mid-bit at %0t", name, $time);
    end
    for (i = 0; i < DATA_BITS; i++)
    begin
      repeat (BAUD_DIV) @(posedge clk);
      b[i] = tx;  // LSB first
    end
    repeat (BAUD_DIV) @(posedge clk);
    par = tx;
    repeat (BAUD_DIV) @(posedge clk);
    check_cmd_byte(name, b, exp);
    check_err({name, " parity"}, par, parity_of(exp));
    check_err({name, " stop"}, tx, 1'b1);
  endtask

  // Drives a reply frame on rx and leaves the stop bit on the line
  task automatic send_reply(data_t b, logic flip);
    logic [FRAME_BITS-1:0] bits;
    int                    i;
    bits = {1'b1, parity_of(b) ^ flip, b, 1'b0};
    for (i = 0; i < FRAME_BITS - 1; i++)
    begin
      rx <= bits[i];
      repeat (BAUD_DIV) @(posedge clk);
    end
    rx <= 1'b1;
  endtask

  task automatic run_read(int r);
    if (row_mode[r] != reply_none)
    begin
      repeat (row_delay[r] * BAUD_DIV) @(posedge clk);
      send_reply(shadow_mem[row_addr[r]], row_mode[r] == reply_bad_par);
    end
    wait_read_rdy();
    check_err("rsp_err", rsp_err, row_err[r]);
    if (row_mode[r] == reply_none)
      check_data("read_data", read_data, '0);
    else if (row_mode[r] == reply_ok)
      check_data("read_data", read_data, shadow_mem[row_addr[r]]);
  endtask

  initial
  begin
    int   i;
    int   idle;
    logic quiet;
    seed         = 32'h2596f14d;
    mismatches   = 0;
    other_errors = 0;
    frames_seen  = 0;
    frames_exp   = 0;
    accepts      = 0;
    frame_left   = 0;
    quiet        = 1'b1;
    rst_n        = 1'b0;
    cmd_in       = '0;
    cmd_vld      = 1'b0;
    rx           = 1'b1;
    for (i = 0; i < 128; i++)
      shadow_mem[i] = data_t'($random(seed));
    set_row(0, op_write, 7'h12, reply_none, 0, 1'b0);
    set_row(1, op_read, 7'h12, reply_ok, 2, 1'b0);
    set_row(2, op_read, 7'h45, reply_ok, 5, 1'b0);
    set_row(3, op_write, 7'h7f, reply_none, 0, 1'b0);
    set_row(4, op_read, 7'h7f, reply_bad_par, 1, 1'b1);
    set_row(5, op_read, 7'h33, reply_none, 0, 1'b1);  // Slave stays silent
    set_row(6, op_write, 7'h00, reply_none, 0, 1'b0);
    set_row(7, op_read, 7'h00, reply_ok, 3, 1'b0);

    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    check_err("tx", tx, 1'b1);
    check_err("cmd_rdy", cmd_rdy, 1'b1);
    check_err("read_rdy", read_rdy, 1'b0);
    check_err("rsp_err", rsp_err, 1'b0);
    check_data("read_data", read_data, '0);

    cmd_in  <= make_cmd(0);
    cmd_vld <= 1'b1;
    for (i = 0; i < N_ROWS; i++)
    begin
      wait_accept();
      if (i + 1 < N_ROWS)
        cmd_in <= make_cmd(i + 1);  // cmd_vld stays high between rows
      else
        cmd_vld <= 1'b0;
      frames_exp += (row_op[i] == op_write) ? 2 : 1;
      check_frame("addr frame", {row_op[i], row_addr[i]}, idle);
      if (row_op[i] == op_write)
      begin
        check_frame("data frame", row_data[i], idle);
        if (idle - HALF_BAUD - 1 < GAP_CYCLES)
        begin
          other_errors++;
          $display("Write gap of row %0d only %0d cycles", i, idle - HALF_BAUD - 1);
        end
        shadow_mem[row_addr[i]] = row_data[i];
      end
      else
        run_read(i);
    end

    // No frame may follow the last row
    repeat (2 * FRAME_BITS * BAUD_DIV)
    begin
      @(posedge clk);
      if (!tx)
        quiet = 1'b0;
    end
    check_err("tx idle after table", quiet, 1'b1);
    check_err("cmd_rdy after table", cmd_rdy, 1'b1);
    if (frames_seen != frames_exp || accepts != N_ROWS)
    begin
      other_errors++;
      $display("Saw %0d frames and %0d accepts, table gives %0d frames and %0d rows",
               frames_seen, accepts, frames_exp, N_ROWS);
    end
    print_counts();
    if (mismatches + other_errors == 0)
      $display("ALL TESTS PASSED");
    else
      $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

/* tb/uart_cmd_sva.sv */
`timescale 1ns/100ps

module uart_cmd_sva (
  input logic                     clk,
  input logic                     rst_n,
  input uart_cmd_pkg::ctrl_state_e state,
  input logic                     cmd_rdy,
  input logic                     tx_start,
  input logic                     tx_busy,
  input logic                     read_rdy
);

  import uart_cmd_pkg::*;

  read_rdy_pulse: assert property (@(posedge clk) disable iff (!rst_n) read_rdy |=> !read_rdy)
    else $error("read_rdy high for more than one cycle");

  rdy_only_idle: assert property (@(posedge clk) disable iff (!rst_n) (state != idle) |-> !cmd_rdy)
    else $error("cmd_rdy high outside idle");

  start_when_free: assert property (@(posedge clk) disable iff (!rst_n) tx_start |-> !tx_busy)
    else $error("tx_start while the serializer is busy");

  // Serializer idle means the line rests high
  line_idle: assert property (@(posedge clk) disable iff (!rst_n) (state == idle) |-> !tx_busy)
    else $error("tx not idle while the sequencer is idle");

endmodule

bind uart_cmd_ctrl uart_cmd_sva uart_cmd_sva_i (
  .clk      (clk),
  .rst_n    (rst_n),
  .state    (state),
  .cmd_rdy  (cmd_rdy),
  .tx_start (tx_start),
  .tx_busy  (tx_busy),
  .read_rdy (read_rdy)
);

/* hdl/uart_cmd_top.sv */
`timescale 1ns/100ps

module uart_cmd_top (
  input  logic                clk,
  input  logic                rst_n,
  input  uart_cmd_pkg::cmd_t  cmd_in,
  input  logic                cmd_vld,
  input  logic                rx,
  output logic                tx,
  output logic                cmd_rdy,
  output logic                read_rdy,
  output logic                rsp_err,
  output uart_cmd_pkg::data_t read_data
);

  import uart_cmd_pkg::*;

  logic  tx_start;
  data_t tx_byte;
  logic  tx_busy;
  logic  rx_start_seen;
  logic  rx_valid;
  logic  rx_bad;
  data_t rx_byte;

  uart_cmd_ctrl uart_cmd_ctrl_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .cmd_in        (cmd_in),
    .cmd_vld       (cmd_vld),
    .cmd_rdy       (cmd_rdy),
    .tx_start      (tx_start),
    .tx_byte       (tx_byte),
    .tx_busy       (tx_busy),
    .rx_start_seen (rx_start_seen),
    .rx_valid      (rx_valid),
    .rx_bad        (rx_bad),
    .rx_byte       (rx_byte),
    .read_rdy      (read_rdy),
    .rsp_err       (rsp_err),
    .read_data     (read_data)
  );

  uart_tx_frame uart_tx_frame_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .tx_start (tx_start),
    .tx_byte  (tx_byte),
    .tx       (tx),
    .tx_busy  (tx_busy)
  );

  // Always listening, the sequencer decides when replies count
  uart_rx_frame uart_rx_frame_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .rx            (rx),
    .rx_start_seen (rx_start_seen),
    .rx_valid      (rx_valid),
    .rx_bad        (rx_bad),
    .rx_byte       (rx_byte)
  );

endmodule

/* hdl/uart_cmd_ctrl.sv */
`timescale 1ns/100ps

module uart_cmd_ctrl (
  input  logic                clk,
  input  logic                rst_n,
  input  uart_cmd_pkg::cmd_t  cmd_in,
  input  logic                cmd_vld,
  output logic                cmd_rdy,
  output logic                tx_start,
  output uart_cmd_pkg::data_t tx_byte,
  input  logic                tx_busy,
  input  logic                rx_start_seen,
  input  logic                rx_valid,
  input  logic                rx_bad,
  input  uart_cmd_pkg::data_t rx_byte,
  output logic                read_rdy,
  output logic                rsp_err,
  output uart_cmd_pkg::data_t read_data
);

  import uart_cfg_pkg::*;
  import uart_cmd_pkg::*;

  ctrl_state_e           state;
  cmd_t                  cmd_q;
  cmd_op_e               op_in;
  cmd_op_e               op_q;
  addr_t                 addr_in;
  data_t                 wr_data;
  logic                  accept;
  logic                  frame_done;
  logic                  gap_end;
  logic                  timeout_end;
  logic [WAIT_CNT_W-1:0] wait_cnt;

  assign accept  = cmd_vld && cmd_rdy;
  assign op_in   = cmd_op_e'(cmd_in[OP_BIT]);
  assign addr_in = cmd_in[ADDR_MSB:ADDR_LSB];
  assign op_q    = cmd_op_e'(cmd_q[OP_BIT]);
  assign wr_data = cmd_q[DATA_MSB:0];

  // Serializer has taken the byte and finished its stop bit
  assign frame_done  = !tx_start && !tx_busy;
  assign gap_end     = (wait_cnt == WAIT_CNT_W'(GAP_CYCLES - 1));
  assign timeout_end = (wait_cnt == WAIT_CNT_W'(TIMEOUT_CYCLES - 1));

  // Command buffer and frame bytes
  always_ff @(posedge clk)
  begin
    if (state == idle && accept)
    begin
      cmd_q   <= cmd_in;
      tx_byte <= {op_in, addr_in};  // Flag on bit 7
    end
    else if (state == gap && gap_end)
      tx_byte <= wr_data;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state     <= idle;
      cmd_rdy   <= 1'b1;
      tx_start  <= 1'b0;
      wait_cnt  <= '0;
      read_rdy  <= 1'b0;
      rsp_err   <= 1'b0;
      read_data <= '0;
    end
    else
    begin
      tx_start <= 1'b0;  // Both strobes are single-cycle
      read_rdy <= 1'b0;
      case (state)
        idle:
        begin
          if (accept)
          begin
            cmd_rdy  <= 1'b0;
            tx_start <= 1'b1;
            state    <= send_addr;
          end
        end
        send_addr:
        begin
          wait_cnt <= '0;  // Gap and timeout both start at frame end
          if (frame_done)
          begin
            case (op_q)
              op_write: state <= gap;
              op_read:  state <= wait_reply;
              default:  state <= idle;
            endcase
          end
        end
        gap:
        begin
          wait_cnt <= wait_cnt + 1'b1;
          if (gap_end)
          begin
            tx_start <= 1'b1;
            state    <= send_data;
          end
        end
        send_data:
        begin
          if (frame_done)
            state <= done;
        end
        wait_reply:
        begin
          wait_cnt <= wait_cnt + 1'b1;
          if (rx_start_seen)
            state <= recv_reply;
          else if (timeout_end)
          begin
            read_rdy  <= 1'b1;  // Slave never answered
            rsp_err   <= 1'b1;
            read_data <= '0;
            state     <= done;
          end
        end
        recv_reply:
        begin
          if (rx_valid)
          begin
            read_rdy  <= 1'b1;
            rsp_err   <= rx_bad;
            read_data <= rx_byte;
            state     <= done;
          end
        end
        done:
        begin
          cmd_rdy <= 1'b1;
          state   <= idle;
        end
        default:
        begin
          cmd_rdy <= 1'b1;
          state   <= idle;
        end
      endcase
    end
  end

endmodule

/* uart_phy/uart_rx_frame.sv */
`timescale 1ns/100ps

module uart_rx_frame (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                rx,
  output logic                rx_start_seen,
  output logic                rx_valid,
  output logic                rx_bad,
  output uart_cmd_pkg::data_t rx_byte
);

  import uart_cfg_pkg::*;

  logic                  rx_meta;
  logic                  rx_sync;
  logic                  rx_prev;
  logic                  busy;
  logic [BAUD_CNT_W-1:0] baud_cnt;
  logic [BIT_IDX_W-1:0]  bit_idx;  // 0 while checking the start bit
  logic [DATA_BITS-1:0]  shift_q;
  logic                  parity_q;
  logic                  rx_fall;
  logic                  half_hit;
  logic                  full_hit;
  logic                  in_data;

  assign rx_fall  = rx_prev && !rx_sync;
  assign half_hit = (baud_cnt == BAUD_CNT_W'(HALF_BAUD - 1));
  assign full_hit = (baud_cnt == BAUD_CNT_W'(BAUD_DIV - 1));
  assign in_data  = (bit_idx != '0) && (bit_idx <= BIT_IDX_W'(DATA_BITS));
  assign rx_byte  = shift_q;

  // Two-flop synchronizer, third flop for the falling edge
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end
    else
    begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  // Mid-bit samples of data and parity
  always_ff @(posedge clk)
  begin
    if (busy && full_hit)
    begin
      if (in_data)
        shift_q <= {rx_sync, shift_q[DATA_BITS-1:1]};
      else if (bit_idx == BIT_IDX_W'(DATA_BITS + 1))
        parity_q <= rx_sync;
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      busy          <= 1'b0;
      baud_cnt      <= '0;
      bit_idx       <= '0;
      rx_start_seen <= 1'b0;
      rx_valid      <= 1'b0;
      rx_bad        <= 1'b0;
    end
    else
    begin
      rx_start_seen <= 1'b0;
      rx_valid      <= 1'b0;
      if (!busy)
      begin
        if (rx_fall)
        begin
          busy     <= 1'b1;
          baud_cnt <= '0;
          bit_idx  <= '0;
        end
      end
      else if (bit_idx == '0)
      begin
        if (!half_hit)
          baud_cnt <= baud_cnt + 1'b1;
        else if (!rx_sync)
        begin
          rx_start_seen <= 1'b1;  // Still low half a bit in
          baud_cnt      <= '0;
          bit_idx       <= BIT_IDX_W'(1);
        end
        else
          busy <= 1'b0;  // Glitch, back to hunting
      end
      else if (!full_hit)
      begin
        baud_cnt <= baud_cnt + 1'b1;
      end
      else
      begin
        baud_cnt <= '0;
        if (bit_idx == BIT_IDX_W'(FRAME_BITS - 1))
        begin
          busy     <= 1'b0;
          rx_valid <= 1'b1;
          // Parity mismatch or low stop bit
          rx_bad   <= (parity_q != (^shift_q ^ PARITY_ODD)) || !rx_sync;
        end
        else
          bit_idx <= bit_idx + 1'b1;
      end
    end
  end

endmodule

/* uart_phy/uart_tx_frame.sv */
`timescale 1ns/100ps

module uart_tx_frame (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                tx_start,
  input  uart_cmd_pkg::data_t tx_byte,
  output logic                tx,
  output logic                tx_busy
);

  import uart_cfg_pkg::*;

  logic [BAUD_CNT_W-1:0] baud_cnt;
  logic [BIT_IDX_W-1:0]  bit_idx;  // 0 start, 1..8 data, 9 parity, 10 stop
  logic [BIT_IDX_W-1:0]  next_idx;
  logic [DATA_BITS-1:0]  shift_q;
  logic                  parity_q;
  logic                  bit_end;
  logic                  next_is_data;

  assign bit_end      = (baud_cnt == BAUD_CNT_W'(BAUD_DIV - 1));
  assign next_idx     = bit_idx + 1'b1;
  assign next_is_data = (next_idx <= BIT_IDX_W'(DATA_BITS));

  // Byte and its parity are captured when the frame is launched
  always_ff @(posedge clk)
  begin
    if (tx_start && !tx_busy)
    begin
      shift_q  <= tx_byte;
      parity_q <= ^tx_byte ^ PARITY_ODD;
    end
    else if (tx_busy && bit_end && next_is_data)
      shift_q <= shift_q >> 1;  // LSB first
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      tx       <= 1'b1;
      tx_busy  <= 1'b0;
      baud_cnt <= '0;
      bit_idx  <= '0;
    end
    else if (!tx_busy)
    begin
      if (tx_start)
      begin
        tx       <= 1'b0;  // Start bit
        tx_busy  <= 1'b1;
        baud_cnt <= '0;
        bit_idx  <= '0;
      end
    end
    else if (!bit_end)
    begin
      baud_cnt <= baud_cnt + 1'b1;
    end
    else
    begin
      baud_cnt <= '0;
      if (bit_idx == BIT_IDX_W'(FRAME_BITS - 1))
      begin
        // End of stop bit, line stays high
        tx      <= 1'b1;
        tx_busy <= 1'b0;
        bit_idx <= '0;
      end
      else
      begin
        bit_idx <= next_idx;
        if (next_is_data)
          tx <= shift_q[0];
        else if (next_idx == BIT_IDX_W'(DATA_BITS + 1))
          tx <= parity_q;
        else
          tx <= 1'b1;  // Stop bit
      end
    end
  end

endmodule

/* common/uart_cmd_pkg.sv */
package uart_cmd_pkg;

  // Command word layout
  localparam int CMD_W    = 16;
  localparam int OP_BIT   = 15;  // 1 write, 0 read
  localparam int ADDR_MSB = 14;
  localparam int ADDR_LSB = 8;
  localparam int ADDR_W   = ADDR_MSB - ADDR_LSB + 1;
  localparam int DATA_MSB = ADDR_LSB - 1;

  typedef logic [CMD_W-1:0]  cmd_t;
  typedef logic [ADDR_W-1:0] addr_t;

  // One serial payload byte
  typedef logic [uart_cfg_pkg::DATA_BITS-1:0] data_t;

  // Operation taken from the top bit of the command
  typedef enum logic {
    op_read  = 1'b0,
    op_write = 1'b1
  } cmd_op_e;

  // Sequencer states
  typedef enum logic [2:0] {
    idle,
    send_addr,   // Flag and address frame on tx
    gap,         // Idle time between write frames
    send_data,   // Write data frame on tx
    wait_reply,  // Read waits for a reply start bit
    recv_reply,  // Reply frame in progress
    done
  } ctrl_state_e;

endpackage

/* common/uart_cfg_pkg.sv */
package uart_cfg_pkg;

  // Bit timing
  localparam int BAUD_DIV   = 16;  // Clocks per bit, the board uses 434
  localparam int HALF_BAUD  = BAUD_DIV / 2;
  localparam int BAUD_CNT_W = $clog2(BAUD_DIV);

  // Frame layout
  localparam int DATA_BITS  = 8;
  localparam int FRAME_BITS = DATA_BITS + 3;  // Start, data, parity, stop
  localparam int BIT_IDX_W  = $clog2(FRAME_BITS);

  // Clear for even parity, set for odd
  localparam logic PARITY_ODD = 1'b0;

  // Idle bit times between the address and data frames of a write
  localparam int GAP_BITS = 4;

  // Bit times allowed for the reply start bit after the address frame
  localparam int RX_TIMEOUT_BITS = 32;

  // Same spacing expressed in clocks
  localparam int GAP_CYCLES     = GAP_BITS * BAUD_DIV;
  localparam int TIMEOUT_CYCLES = RX_TIMEOUT_BITS * BAUD_DIV;

  // One counter serves both the gap and the reply timeout
  localparam int WAIT_CNT_W = $clog2(TIMEOUT_CYCLES + GAP_CYCLES);

endpackage
